/* logic/ptw_mem_pkg.sv */
`default_nettype none

package ptw_mem_pkg;

  // page numbers for 4 KiB pages in a 32 bit space
  typedef logic [19:0] vpn_t;
  typedef logic [19:0] ppn_t;
  typedef logic [31:0] paddr_t;
  typedef logic [31:0] pte_t;

  // page table entry fields
  localparam int PTE_PRESENT = 0;
  localparam int PTE_WRITE   = 1;
  localparam int PTE_USER    = 2;
  localparam int PTE_HUGE    = 3;
  localparam int PTE_PPN_LSB = 12;

  // two levels of 1024 entries, four bytes per entry
  localparam int PT_IDX_W       = 10;
  localparam int PTE_ADDR_SHIFT = 2;

  typedef logic [PT_IDX_W-1:0] pt_idx_t;

  // reads one memory port may have in flight
  localparam int MEM_CREDITS = 2;
  localparam int CREDIT_W    = $clog2(MEM_CREDITS + 1);

  typedef logic [CREDIT_W-1:0] credit_t;

endpackage

`default_nettype wire

/* logic/ptw_ctrl_pkg.sv */
`default_nettype none

package ptw_ctrl_pkg;

  typedef logic [15:0] csr_no_t;

  localparam csr_no_t CSR_PT_ROOT = 16'h0010;
  localparam csr_no_t CSR_PT_CTRL = 16'h0011;

  // root ppn sits in the upper data bits
  localparam int CSR_ROOT_LSB    = 12;
  localparam int CSR_CTRL_PG_BIT = 0;

  // fill flags, present in bit 0
  typedef logic [3:0] fill_flags_t;

  localparam int FLAG_PRESENT = 0;
  localparam int FLAG_WRITE   = 1;
  localparam int FLAG_USER    = 2;
  localparam int FLAG_HUGE    = 3;

  // flags of an identity mapping with paging off
  localparam fill_flags_t IDENTITY_FLAGS =
    fill_flags_t'((1 << FLAG_PRESENT) | (1 << FLAG_WRITE));

  typedef enum logic [2:0] {
    idle, req_l1, wait_l1, req_l2, wait_l2, done
  } walk_state_t;

endpackage

`default_nettype wire

/* logic/ptw_ifs.sv */
`default_nettype none

// launch of one walk
interface walk_cmd_if import ptw_mem_pkg::*; ();
  logic start;
  vpn_t vpn;
  ppn_t root;
  logic paging_en;

  modport src (
    output start, vpn, root, paging_en
  );

  modport dst (
    input start, vpn, root, paging_en
  );
endinterface

// result of one walk, fault has present clear
interface walk_res_if import ptw_mem_pkg::*, ptw_ctrl_pkg::*; ();
  logic        done;
  ppn_t        ppn;
  fill_flags_t flags;

  modport src (
    output done, ppn, flags
  );

  modport dst (
    input done, ppn, flags
  );
endinterface

`default_nettype wire

/* logic/walk_dispatch.sv */
`default_nettype none

module walk_dispatch import ptw_mem_pkg::*, ptw_ctrl_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      req_en,
  input  vpn_t      req_vpn,
  output logic      req_can,
  input  logic      csr_en,
  input  csr_no_t   csr_no,
  input  logic [31:0] csr_data,
  input  logic      fill_valid,
  output vpn_t      req_vpn_q,
  walk_cmd_if.src   cmd_a,
  walk_cmd_if.src   cmd_b
);

  ppn_t root_ppn;
  logic paging_en;
  ppn_t root_snap;
  logic paging_snap;
  logic start_q;
  logic accept;

  assign accept = req_en && req_can;

  // paging configuration
  always_ff @(posedge clk) begin
    if (rst) begin
      root_ppn  <= '0;
      paging_en <= 1'b0;
    end else if (csr_en) begin
      if (csr_no == CSR_PT_ROOT) begin
        root_ppn  <= csr_data[CSR_ROOT_LSB +: $bits(ppn_t)];
        paging_en <= 1'b1;
      end else if (csr_no == CSR_PT_CTRL) begin
        paging_en <= csr_data[CSR_CTRL_PG_BIT];
      end
    end
  end

  // busy from acceptance to the cycle after the fill
  always_ff @(posedge clk) begin
    if (rst) begin
      req_can <= 1'b1;
      start_q <= 1'b0;
    end else begin
      start_q <= accept;
      if (accept) req_can <= 1'b0;
      else if (fill_valid) req_can <= 1'b1;
    end
  end

  // later csr writes do not touch a running walk
  always_ff @(posedge clk) begin
    if (accept) begin
      req_vpn_q   <= req_vpn;
      root_snap   <= root_ppn;
      paging_snap <= paging_en;
    end
  end

  assign cmd_a.start     = start_q;
  assign cmd_a.vpn       = req_vpn_q;
  assign cmd_a.root      = root_snap;
  assign cmd_a.paging_en = paging_snap;

  // next page wraps at the top of the space
  assign cmd_b.start     = start_q;
  assign cmd_b.vpn       = req_vpn_q + vpn_t'(1);
  assign cmd_b.root      = root_snap;
  assign cmd_b.paging_en = paging_snap;

  // a new walk never meets the fill of the previous one
  a_start_while_busy: assert property (@(posedge clk) disable iff (rst)
    start_q |-> !req_can && !fill_valid);

endmodule

`default_nettype wire

/* logic/page_walker.sv */
`default_nettype none

module page_walker import ptw_mem_pkg::*, ptw_ctrl_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  walk_cmd_if.dst cmd,
  walk_res_if.src res,
  output logic    mem_req_valid,
  output paddr_t  mem_req_addr,
  input  logic    mem_resp_valid,
  input  pte_t    mem_resp_data,
  input  logic    mem_credit
);

  walk_state_t state;
  credit_t     credits;
  vpn_t        vpn_q;
  ppn_t        table_ppn;
  ppn_t        ppn_q;
  fill_flags_t flags_q;
  pt_idx_t     l1_idx;
  pt_idx_t     l2_idx;
  ppn_t        resp_ppn;
  logic        resp_fault;
  logic        resp_huge;

  function automatic fill_flags_t pte_flags(input pte_t pte, input logic huge);
    fill_flags_t f;
    f = '0;
    f[FLAG_PRESENT] = pte[PTE_PRESENT];
    f[FLAG_WRITE]   = pte[PTE_WRITE];
    f[FLAG_USER]    = pte[PTE_USER];
    f[FLAG_HUGE]    = huge;
    return f;
  endfunction

  assign l1_idx     = vpn_q[PT_IDX_W +: PT_IDX_W];
  assign l2_idx     = vpn_q[0 +: PT_IDX_W];
  assign resp_ppn   = mem_resp_data[PTE_PPN_LSB +: $bits(ppn_t)];
  assign resp_fault = !mem_resp_data[PTE_PRESENT];
  assign resp_huge  = mem_resp_data[PTE_HUGE];

  // a read goes out only with a credit in hand
  assign mem_req_valid = ((state == req_l1) || (state == req_l2)) && (credits != '0);
  assign mem_req_addr  = {table_ppn, (state == req_l2) ? l2_idx : l1_idx,
                          {PTE_ADDR_SHIFT{1'b0}}};

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
    end else begin
      case (state)
        idle:    if (cmd.start) state <= cmd.paging_en ? req_l1 : done;
        req_l1:  if (mem_req_valid) state <= wait_l1;
        wait_l1: if (mem_resp_valid) state <= (resp_fault || resp_huge) ? done : req_l2;
        req_l2:  if (mem_req_valid) state <= wait_l2;
        wait_l2: if (mem_resp_valid) state <= done;
        default: state <= idle;
      endcase
    end
  end

  // walk context and result
  always_ff @(posedge clk) begin
    case (state)
      idle: begin
        if (cmd.start) begin
          vpn_q     <= cmd.vpn;
          table_ppn <= cmd.root;
          ppn_q     <= cmd.vpn;
          flags_q   <= IDENTITY_FLAGS;
        end
      end
      wait_l1: begin
        if (mem_resp_valid) begin
          if (resp_fault) begin
            ppn_q   <= '0;
            flags_q <= '0;
          end else if (resp_huge) begin
            // upper ppn from the entry and lower part from the vpn
            ppn_q   <= {resp_ppn[$bits(ppn_t)-1:PT_IDX_W], l2_idx};
            flags_q <= pte_flags(mem_resp_data, 1'b1);
          end else begin
            table_ppn <= resp_ppn;
          end
        end
      end
      wait_l2: begin
        if (mem_resp_valid) begin
          ppn_q   <= resp_fault ? '0 : resp_ppn;
          flags_q <= resp_fault ? '0 : pte_flags(mem_resp_data, 1'b0);
        end
      end
      default: begin
      end
    endcase
  end

  // one credit back per request memory dequeues
  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= credit_t'(MEM_CREDITS);
    end else if (mem_req_valid && !mem_credit) begin
      credits <= credits - credit_t'(1);
    end else if (!mem_req_valid && mem_credit) begin
      credits <= credits + credit_t'(1);
    end
  end

  assign res.done  = (state == done);
  assign res.ppn   = ppn_q;
  assign res.flags = flags_q;

  // without a credit the walk holds in its request state
  a_stall_without_credit: assert property (@(posedge clk) disable iff (rst)
    ((state == req_l1) || (state == req_l2)) && (credits == '0) |=> $stable(state));

  a_credit_bound: assert property (@(posedge clk) disable iff (rst)
    credits <= credit_t'(MEM_CREDITS));

endmodule

`default_nettype wire

/* logic/tlb_fill_merge.sv */
`default_nettype none

module tlb_fill_merge import ptw_mem_pkg::*, ptw_ctrl_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  walk_res_if.dst     res_a,
  walk_res_if.dst     res_b,
  input  vpn_t        req_vpn_q,
  output logic        fill_valid,
  output vpn_t        fill_vpn,
  output ppn_t        fill0_ppn,
  output fill_flags_t fill0_flags,
  output ppn_t        fill1_ppn,
  output fill_flags_t fill1_flags
);

  logic        got_a;
  logic        got_b;
  ppn_t        hold_a_ppn;
  fill_flags_t hold_a_flags;
  ppn_t        hold_b_ppn;
  fill_flags_t hold_b_flags;
  logic        both;
  logic        page0_ok;

  assign both     = got_a && got_b;
  assign page0_ok = hold_a_flags[FLAG_PRESENT];

  // walkers may finish in either order
  always_ff @(posedge clk) begin
    if (rst) begin
      got_a      <= 1'b0;
      got_b      <= 1'b0;
      fill_valid <= 1'b0;
    end else begin
      fill_valid <= both;
      if (both) begin
        got_a <= 1'b0;
        got_b <= 1'b0;
      end else begin
        if (res_a.done) got_a <= 1'b1;
        if (res_b.done) got_b <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (res_a.done) begin
      hold_a_ppn   <= res_a.ppn;
      hold_a_flags <= res_a.flags;
    end
    if (res_b.done) begin
      hold_b_ppn   <= res_b.ppn;
      hold_b_flags <= res_b.flags;
    end
  end

  // a fault on page 0 hides page 1
  always_ff @(posedge clk) begin
    if (both) begin
      fill_vpn    <= req_vpn_q;
      fill0_ppn   <= hold_a_ppn;
      fill0_flags <= hold_a_flags;
      fill1_ppn   <= page0_ok ? hold_b_ppn : '0;
      fill1_flags <= page0_ok ? hold_b_flags : '0;
    end
  end

  a_single_done_a: assert property (@(posedge clk) disable iff (rst)
    res_a.done |-> !got_a);

  a_single_done_b: assert property (@(posedge clk) disable iff (rst)
    res_b.done |-> !got_b);

endmodule

`default_nettype wire

/* logic/pager_top.sv */
`default_nettype none

module pager_top import ptw_mem_pkg::*, ptw_ctrl_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        req_en,
  input  vpn_t        req_vpn,
  output logic        req_can,
  input  logic        csr_en,
  input  csr_no_t     csr_no,
  input  logic [31:0] csr_data,
  output logic        mem_req_valid_a,
  output paddr_t      mem_req_addr_a,
  input  logic        mem_resp_valid_a,
  input  pte_t        mem_resp_data_a,
  input  logic        mem_credit_a,
  output logic        mem_req_valid_b,
  output paddr_t      mem_req_addr_b,
  input  logic        mem_resp_valid_b,
  input  pte_t        mem_resp_data_b,
  input  logic        mem_credit_b,
  output logic        fill_valid,
  output vpn_t        fill_vpn,
  output ppn_t        fill0_ppn,
  output fill_flags_t fill0_flags,
  output ppn_t        fill1_ppn,
  output fill_flags_t fill1_flags
);

  vpn_t req_vpn_q;

  walk_cmd_if cmd_a ();
  walk_cmd_if cmd_b ();
  walk_res_if res_a ();
  walk_res_if res_b ();

  walk_dispatch u_dispatch (
    .clk, .rst, .req_en, .req_vpn, .req_can,
    .csr_en, .csr_no, .csr_data, .fill_valid, .req_vpn_q,
    .cmd_a (cmd_a.src),
    .cmd_b (cmd_b.src)
  );

  // request page
  page_walker u_walk_a (
    .clk, .rst,
    .cmd            (cmd_a.dst),
    .res            (res_a.src),
    .mem_req_valid  (mem_req_valid_a),
    .mem_req_addr   (mem_req_addr_a),
    .mem_resp_valid (mem_resp_valid_a),
    .mem_resp_data  (mem_resp_data_a),
    .mem_credit     (mem_credit_a)
  );

  // following page
  page_walker u_walk_b (
    .clk, .rst,
    .cmd            (cmd_b.dst),
    .res            (res_b.src),
    .mem_req_valid  (mem_req_valid_b),
    .mem_req_addr   (mem_req_addr_b),
    .mem_resp_valid (mem_resp_valid_b),
    .mem_resp_data  (mem_resp_data_b),
    .mem_credit     (mem_credit_b)
  );

  tlb_fill_merge u_merge (
    .clk, .rst,
    .res_a (res_a.dst),
    .res_b (res_b.dst),
    .req_vpn_q, .fill_valid, .fill_vpn,
    .fill0_ppn, .fill0_flags, .fill1_ppn, .fill1_flags
  );

endmodule

`default_nettype wire

/* tests/pt_table.svh */
// entry content follows from the entry address, no table is stored
localparam logic [31:0] PT_KEY = 32'h6d2b_91c5;

// mix of absent, huge and table entries
function automatic pte_t pte_at(input paddr_t addr);
  logic [31:0] h;
  pte_t        pte;
  h = (addr ^ PT_KEY) * 32'h9e37_79b1;
  h = h ^ (h >> 16);
  h = h * 32'h85eb_ca6b;
  h = h ^ (h >> 13);
  pte = {h[31:12], 12'h000};
  pte[PTE_WRITE] = h[8];
  pte[PTE_USER]  = h[9];
  if (h[7:4] < 4'd2) begin
    // absent, huge bit is junk here
    pte[PTE_PRESENT] = 1'b0;
    pte[PTE_HUGE]    = h[10];
  end else begin
    pte[PTE_PRESENT] = 1'b1;
    pte[PTE_HUGE]    = (h[7:4] < 4'd5);
  end
  return pte;
endfunction

/* tests/pt_mem_model.sv */
`default_nettype none

module pt_mem_model import ptw_mem_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   req_valid,
  input  paddr_t req_addr,
  output logic   resp_valid,
  output pte_t   resp_data,
  output logic   credit,
  output logic   overflow
);

  `include "pt_table.svh"

  paddr_t q_addr[$];
  int     seed = 32'hbc02_3ed9;
  int     rnd;
  int     delay = 0;
  int     owed = 0;
  logic   resp_q = 1'b0;
  pte_t   data_q = '0;
  logic   credit_q = 1'b0;
  logic   over_q = 1'b0;

  assign resp_valid = resp_q;
  assign resp_data  = data_q;
  assign credit     = credit_q;
  assign overflow   = over_q;

  // a slot stays taken until its credit goes back
  always @(posedge clk) begin
    if (!rst && req_valid) begin
      if (q_addr.size() + owed >= MEM_CREDITS) over_q <= 1'b1;
      q_addr.push_back(req_addr);
    end
  end

  always @(negedge clk) begin
    rnd      = $random(seed);
    resp_q   = 1'b0;
    credit_q = 1'b0;
    if (rst) begin
      q_addr.delete();
      delay = 0;
      owed  = 0;
    end else begin
      if (q_addr.size() != 0) begin
        // 1 to 4 cycles per read, in order
        if (delay == 0) delay = 1 + (rnd & 3);
        delay = delay - 1;
        if (delay == 0) begin
          resp_q = 1'b1;
          data_q = pte_at(q_addr.pop_front());
          owed   = owed + 1;
        end
      end
      // credit may lag the answer
      if (owed != 0 && rnd[2]) begin
        credit_q = 1'b1;
        owed     = owed - 1;
      end
    end
  end

endmodule

`default_nettype wire

/* tests/tb_pager.sv */
`default_nettype none

module tb_pager import ptw_mem_pkg::*, ptw_ctrl_pkg::*; ();

  `include "pt_table.svh"

  localparam int N_ID    = 3;
  localparam int N_RAND  = 40;
  localparam int N_PICK  = 4;
  localparam int N_BURST = 10;
  // identity twice, random, three picked kinds, two wraps, one burst
  localparam int N_REQ      = 2 * N_ID + N_RAND + 3 * N_PICK + 2 + N_BURST;
  localparam int MAX_CYCLES = 60 * N_REQ + 100;

  typedef struct packed {
    vpn_t        vpn;
    logic [23:0] e0;
    logic [23:0] e1;
    logic [31:0] cyc;
    logic        pg;
  } expect_t;

  logic        clk = 1'b0;
  logic        rst, req_en, req_can, csr_en, fill_valid;
  vpn_t        req_vpn, fill_vpn;
  csr_no_t     csr_no;
  logic [31:0] csr_data;
  logic        mem_req_valid_a, mem_resp_valid_a, mem_credit_a, overflow_a;
  logic        mem_req_valid_b, mem_resp_valid_b, mem_credit_b, overflow_b;
  paddr_t      mem_req_addr_a, mem_req_addr_b;
  pte_t        mem_resp_data_a, mem_resp_data_b;
  ppn_t        fill0_ppn, fill1_ppn;
  fill_flags_t fill0_flags, fill1_flags;

  int      seed = 32'hbc02_3ed9;
  int      cycle = 0;
  int      accepts = 0;
  int      blocked = 0;
  ppn_t    root_ref = '0;
  logic    pg_ref = 1'b0;
  expect_t pending[$];
  expect_t head;

  always #4 clk = ~clk;

  pager_top i_dut (.*);

  pt_mem_model u_mem_a (
    .clk, .rst,
    .req_valid  (mem_req_valid_a),
    .req_addr   (mem_req_addr_a),
    .resp_valid (mem_resp_valid_a),
    .resp_data  (mem_resp_data_a),
    .credit     (mem_credit_a),
    .overflow   (overflow_a)
  );

  pt_mem_model u_mem_b (
    .clk, .rst,
    .req_valid  (mem_req_valid_b),
    .req_addr   (mem_req_addr_b),
    .resp_valid (mem_resp_valid_b),
    .resp_data  (mem_resp_data_b),
    .credit     (mem_credit_b),
    .overflow   (overflow_b)
  );

  // expected {ppn, flags} of one page
  function automatic logic [23:0] ref_walk(input vpn_t vpn, input ppn_t root, input logic pg);
    pte_t l1;
    pte_t l2;
    // identity mapping is present and writable
    if (!pg) return {vpn, 4'b0011};
    l1 = pte_at({root, vpn[19:10], 2'b00});
    if (!l1[PTE_PRESENT]) return '0;
    if (l1[PTE_HUGE]) return {l1[31:22], vpn[9:0], 1'b1, l1[PTE_USER], l1[PTE_WRITE], 1'b1};
    l2 = pte_at({l1[31:12], vpn[9:0], 2'b00});
    if (!l2[PTE_PRESENT]) return '0;
    return {l2[31:12], 1'b0, l2[PTE_USER], l2[PTE_WRITE], 1'b1};
  endfunction

  function automatic expect_t predict(input vpn_t vpn);
    expect_t e;
    vpn_t    nxt;
    nxt   = vpn + vpn_t'(1);
    e.vpn = vpn;
    e.e0  = ref_walk(vpn, root_ref, pg_ref);
    // fault on the request page hides the next one
    e.e1  = e.e0[FLAG_PRESENT] ? ref_walk(nxt, root_ref, pg_ref) : '0;
    e.cyc = cycle;
    e.pg  = pg_ref;
    return e;
  endfunction

  function automatic vpn_t rand_vpn();
    logic [31:0] r;
    r = $random(seed);
    return r[19:0];
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      stop_run($sformatf("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp));
  endtask

  task automatic send_req(input vpn_t vpn);
    @(negedge clk);
    while (!req_can) @(negedge clk);
    req_en  = 1'b1;
    req_vpn = vpn;
    @(negedge clk);
    req_en  = 1'b0;
  endtask

  task automatic wait_idle();
    while (!req_can || pending.size() != 0) @(negedge clk);
  endtask

  task automatic csr_write(input csr_no_t no, input logic [31:0] data);
    wait_idle();
    csr_en   = 1'b1;
    csr_no   = no;
    csr_data = data;
    @(negedge clk);
    csr_en   = 1'b0;
  endtask

  // kind 0 huge page 0, kind 1 fault on page 0, else fault on page 1 only
  task automatic pick_vpn(input int kind, output vpn_t v);
    logic [23:0] e0;
    logic [23:0] e1;
    logic        found;
    found = 1'b0;
    for (int i = 0; i < 4000 && !found; i++) begin
      v  = rand_vpn();
      e0 = ref_walk(v, root_ref, 1'b1);
      e1 = ref_walk(v + vpn_t'(1), root_ref, 1'b1);
      case (kind)
        0: found = e0[FLAG_HUGE];
        1: found = !e0[FLAG_PRESENT];
        default: found = e0[FLAG_PRESENT] && !e1[FLAG_PRESENT];
      endcase
    end
    if (!found) stop_run("no vpn of the wanted kind found in the page table");
  endtask

  // req_en stays high while the DUT is busy
  task automatic burst(input int n);
    int target;
    target = accepts + n;
    @(negedge clk);
    while (accepts < target) begin
      req_en  = 1'b1;
      req_vpn = rand_vpn();
      @(negedge clk);
    end
    req_en = 1'b0;
  endtask

  // accept, fill and csr tracking on the rising edge
  always @(posedge clk) begin
    if (!rst) begin
      cycle = cycle + 1;
      if (cycle > MAX_CYCLES) stop_run("timeout, fills stopped coming");
      if (overflow_a || overflow_b) stop_run("memory read sent without a credit");
      if (fill_valid) begin
        if (pending.size() == 0) begin
          stop_run("fill without an accepted request");
        end else begin
          head = pending.pop_front();
          check("fill_vpn", 32'(fill_vpn), 32'(head.vpn));
          check("fill0_ppn", 32'(fill0_ppn), 32'(head.e0[23:4]));
          check("fill0_flags", 32'(fill0_flags), 32'(head.e0[3:0]));
          check("fill1_ppn", 32'(fill1_ppn), 32'(head.e1[23:4]));
          check("fill1_flags", 32'(fill1_flags), 32'(head.e1[3:0]));
          // rises on the third edge after acceptance and is seen one edge later
          if (!head.pg) check("fill latency", cycle - head.cyc, 32'd4);
        end
      end
      if (req_en && !req_can) blocked = blocked + 1;
      if (req_en && req_can) begin
        pending.push_back(predict(req_vpn));
        accepts = accepts + 1;
      end
      if (csr_en && csr_no == CSR_PT_ROOT) begin
        root_ref = csr_data[31:12];
        pg_ref   = 1'b1;
      end else if (csr_en && csr_no == CSR_PT_CTRL) begin
        pg_ref = csr_data[0];
      end
    end
  end

  initial begin
    vpn_t v;
    rst      = 1'b1;
    req_en   = 1'b0;
    req_vpn  = '0;
    csr_en   = 1'b0;
    csr_no   = '0;
    csr_data = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check("req_can", 32'(req_can), 32'd1);
    check("fill_valid", 32'(fill_valid), 32'd0);
    repeat (N_ID) send_req(rand_vpn());
    csr_write(CSR_PT_ROOT, {20'h1_2345, 12'h000});
    repeat (N_RAND) send_req(rand_vpn());
    for (int kind = 0; kind < 3; kind++) begin
      repeat (N_PICK) begin
        pick_vpn(kind, v);
        send_req(v);
      end
    end
    // wrap of the next page and the return to identity
    send_req(20'hf_ffff);
    csr_write(CSR_PT_CTRL, 32'h0);
    repeat (N_ID) send_req(rand_vpn());
    send_req(20'hf_ffff);
    csr_write(CSR_PT_CTRL, 32'h1);
    burst(N_BURST);
    wait_idle();
    repeat (20) @(negedge clk);
    if (blocked == 0) begin
      stop_run("requests held during a walk were never refused");
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+tests
logic/ptw_mem_pkg.sv
logic/ptw_ctrl_pkg.sv
logic/ptw_ifs.sv
logic/walk_dispatch.sv
logic/page_walker.sv
logic/tlb_fill_merge.sv
logic/pager_top.sv
tests/pt_mem_model.sv
tests/tb_pager.sv

/* run.sh */
#!/usr/bin/env bash
# build with Verilator, pass only if the simulation prints its pass line
cd "$(dirname "$0")" &&
verilator --binary --timing -f sources.f --top-module tb_pager -o tb_pager &&
./obj_dir/tb_pager | tee /dev/stderr | grep -q "^Verification passed$" &&
echo "simulation run: PASS" ||
{ echo "simulation run: FAIL"; exit 1; }
